/* tb.f */
+incdir+tb
design/rv32i_pkg.sv
design/bp_pkg.sv
design/branch_unit.sv
design/btb.sv
design/redirect_ctrl.sv
design/branch_perf_counters.sv
design/branch_resolve_top.sv
tb/tb_branch_resolve.sv

/* Bender.yml */
package:
  name: branch_resolve

sources:
  - files:
      - design/rv32i_pkg.sv
      - design/bp_pkg.sv
      - design/branch_unit.sv
      - design/btb.sv
      - design/redirect_ctrl.sv
      - design/branch_perf_counters.sv
      - design/branch_resolve_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_branch_resolve.sv

/* tb/branch_vectors.svh */
`ifndef BRANCH_VECTORS_SVH
`define BRANCH_VECTORS_SVH

// row fields are opcode, funct3, pc, immediate, operand mode (0 fixed, 1 lfsr, 2 lfsr with
// rs2 = rs1), rs1, rs2, predicted taken, predicted target, cycles of redirect_ready low,
// shadow op behind

localparam rv32i_pkg::op_b_t br   = rv32i_pkg::op_b_br;
localparam rv32i_pkg::op_b_t jal  = rv32i_pkg::op_b_jal;
localparam rv32i_pkg::op_b_t jalr = rv32i_pkg::op_b_jalr;

localparam logic [2:0] f_beq  = rv32i_pkg::branch_f3_beq;
localparam logic [2:0] f_bne  = rv32i_pkg::branch_f3_bne;
localparam logic [2:0] f_blt  = rv32i_pkg::branch_f3_blt;
localparam logic [2:0] f_bge  = rv32i_pkg::branch_f3_bge;
localparam logic [2:0] f_bltu = rv32i_pkg::branch_f3_bltu;
localparam logic [2:0] f_bgeu = rv32i_pkg::branch_f3_bgeu;

localparam int NUM_VECTORS = 30;

localparam vec_t vectors [NUM_VECTORS] = '{
    // compare kinds with fixed operands
    '{br, f_beq, 32'h1000, 32'h10, 2'd0, 32'h5, 32'h5, '0, 32'h0, 4'd0, '0},
    '{br, f_beq, 32'h1020, 32'h10, 2'd0, 32'h5, 32'h6, '0, 32'h0, 4'd0, '0},
    '{br, f_bne, 32'h1040, 32'h10, 2'd0, 32'h7, 32'h7, '0, 32'h0, 4'd0, '0},
    '{br, f_bne, 32'h1060, 32'hffff_ffe0, 2'd0, 32'h7, 32'h8, '1, 32'h1040, 4'd0, '0},
    '{br, f_blt, 32'h1080, 32'h10, 2'd0, 32'hffff_ffff, 32'h1, '0, 32'h0, 4'd3, '0},
    '{br, f_blt, 32'h10a0, 32'h10, 2'd0, 32'h1, 32'hffff_ffff, '0, 32'h0, 4'd0, '0},
    '{br, f_bge, 32'h10c0, 32'h10, 2'd0, 32'h9, 32'h9, '1, 32'h10d0, 4'd0, '0},
    '{br, f_bge, 32'h10e0, 32'h10, 2'd0, 32'hffff_fff0, 32'h3, '1, 32'h10f0, 4'd0, '0},
    '{br, f_bltu, 32'h1100, 32'h10, 2'd0, 32'h1, 32'hffff_ffff, '1, 32'h1110, 4'd0, '0},
    '{br, f_bltu, 32'h1120, 32'h10, 2'd0, 32'hffff_ffff, 32'h1, '0, 32'h0, 4'd0, '0},
    '{br, f_bgeu, 32'h1140, 32'h10, 2'd0, 32'h4, 32'h4, '1, 32'h1150, 4'd0, '0},
    '{br, f_bgeu, 32'h1160, 32'h10, 2'd0, 32'h3, 32'h8000_0000, '0, 32'h0, 4'd0, '0},
    '{br, f_beq, 32'h1300, 32'h10, 2'd0, 32'h9, 32'h5, '0, 32'h0, 4'd0, '0},
    '{br, f_bne, 32'h1320, 32'h10, 2'd0, 32'h9, 32'h5, '1, 32'h1330, 4'd0, '0},
    '{br, f_blt, 32'h1340, 32'h10, 2'd0, 32'hffff_fff0, 32'hffff_fff0, '0, 32'h0, 4'd0, '0},
    '{br, f_bge, 32'h1360, 32'h10, 2'd0, 32'h3, 32'hffff_fff0, '1, 32'h1370, 4'd0, '0},
    '{br, f_bltu, 32'h1380, 32'h10, 2'd0, 32'h8000_0000, 32'h8000_0000, '0, 32'h0, 4'd0, '0},
    '{br, f_bgeu, 32'h13a0, 32'h10, 2'd0, 32'h8000_0000, 32'h3, '0, 32'h0, 4'd0, '0},
    // lfsr operands
    '{br, f_beq, 32'h1180, 32'h20, 2'd2, 32'h0, 32'h0, '0, 32'h0, 4'd0, '1},
    '{br, f_bne, 32'h11a0, 32'h20, 2'd1, 32'h0, 32'h0, '0, 32'h0, 4'd1, '0},
    '{br, f_blt, 32'h11c0, 32'h20, 2'd1, 32'h0, 32'h0, '0, 32'h0, 4'd0, '0},
    '{br, f_bge, 32'h11e0, 32'h10, 2'd1, 32'h0, 32'h0, '1, 32'h11f0, 4'd0, '0},
    '{br, f_bltu, 32'h1200, 32'h20, 2'd1, 32'h0, 32'h0, '0, 32'h0, 4'd0, '1},
    '{br, f_bgeu, 32'h1220, 32'h20, 2'd1, 32'h0, 32'h0, '0, 32'h0, 4'd0, '0},
    // jumps
    '{jal, 3'd0, 32'h1240, 32'h800, 2'd0, 32'h0, 32'h0, '1, 32'h1a40, 4'd0, '1},
    '{jal, 3'd0, 32'h1260, 32'hffff_ff00, 2'd0, 32'h0, 32'h0, '0, 32'h0, 4'd2, '0},
    '{jalr, 3'd0, 32'h1280, 32'h25, 2'd0, 32'h2000, 32'h0, '1, 32'h2024, 4'd0, '0},
    '{jalr, 3'd0, 32'h12a0, 32'hffff_fffc, 2'd0, 32'h3001, 32'h0, '1, 32'h3000, 4'd0, '1},
    '{jalr, 3'd0, 32'h12c0, 32'h0, 2'd1, 32'h0, 32'h0, '0, 32'h0, 4'd0, '0},
    // right direction, wrong target
    '{br, f_bne, 32'h12e0, 32'h40, 2'd0, 32'h1, 32'h2, '1, 32'h1400, 4'd4, '0}
};

`endif

/* tb/tb_branch_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_resolve;

    typedef struct packed {
        rv32i_pkg::op_b_t opcode;
        logic [2:0]       funct3;
        logic [31:0]      pc;
        logic [31:0]      imm;
        logic [1:0]       mode;
        logic [31:0]      rs1;
        logic [31:0]      rs2;
        logic             bp;
        logic [31:0]      bp_addr;
        logic [3:0]       hold;
        logic             shadow;
    } vec_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
        logic [31:0] link;
        logic        mispredict;
        logic [31:0] fix_pc;
    } outcome_t;

    typedef struct packed {
        int         due;
        logic [5:0] tag;
        outcome_t   res;
    } expect_t;

`include "branch_vectors.svh"

    localparam int WATCHDOG_CYCLES = NUM_VECTORS * 40 + 50;

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                issue_valid;
    rv32i_pkg::decode_info_t             issue_op;
    logic [31:0]                         rs1_value;
    logic [31:0]                         rs2_value;
    logic                                issue_ready;
    bp_pkg::br_result_t                  result;
    logic                                redirect_valid;
    bp_pkg::redirect_t                   redirect_out;
    logic                                redirect_ready;
    logic [31:0]                         lookup_pc;
    bp_pkg::btb_rd_t                     lookup;
    logic [bp_pkg::PERF_CNT_BITS-1:0]    resolved_count;
    logic [bp_pkg::PERF_CNT_BITS-1:0]    taken_count;
    logic [bp_pkg::PERF_CNT_BITS-1:0]    mispredict_count;

    int          cycle = 0;
    logic [31:0] lfsr_state = 32'd47;
    logic [5:0]  next_tag = 6'd0;
    expect_t     expected_q [$];
    expect_t     head;
    int          resolved_total = 0;
    int          taken_total = 0;
    int          mispredict_total = 0;
    bit          btb_valid [bp_pkg::BTB_ENTRIES];
    logic [31:0] btb_target [bp_pkg::BTB_ENTRIES];

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    branch_resolve_top branch_resolve_top_i (
        .clk              (clk),
        .rst              (rst),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .rs1_value        (rs1_value),
        .rs2_value        (rs2_value),
        .issue_ready      (issue_ready),
        .result           (result),
        .redirect_valid   (redirect_valid),
        .redirect_out     (redirect_out),
        .redirect_ready   (redirect_ready),
        .lookup_pc        (lookup_pc),
        .lookup           (lookup),
        .resolved_count   (resolved_count),
        .taken_count      (taken_count),
        .mispredict_count (mispredict_count)
    );

    // ******************************
    // helpers
    // ******************************

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            w[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // outcome from the isa rules and the redirect rule
    function automatic outcome_t resolve_ref(input rv32i_pkg::decode_info_t op,
                                             input logic [31:0] a, input logic [31:0] b);
        outcome_t o;
        logic     cond;
        o = '0;
        case (op.funct3[2:1])
            2'b00:   cond = (a == b);
            2'b10:   cond = ($signed(a) < $signed(b));
            2'b11:   cond = (a < b);
            default: cond = 1'b0;
        endcase
        if (op.opcode == rv32i_pkg::op_b_jal) begin
            o.taken  = 1'b1;
            o.target = op.pc + 32'($signed(op.j_imm));
            o.link   = op.pc + 32'd4;
        end else if (op.opcode == rv32i_pkg::op_b_jalr) begin
            o.taken  = 1'b1;
            o.target = (a + 32'($signed(op.i_imm))) & 32'hffff_fffe;
            o.link   = op.pc + 32'd4;
        end else begin
            // odd funct3 inverts the compare
            o.taken  = cond ^ op.funct3[0];
            o.target = op.pc + 32'($signed(op.b_imm));
        end
        if (o.taken) begin
            o.mispredict = !op.bp || (op.bp_addr != o.target);
            o.fix_pc     = o.target;
        end else begin
            o.mispredict = op.bp;
            o.fix_pc     = op.pc + 32'd4;
        end
        return o;
    endfunction

    function automatic rv32i_pkg::decode_info_t make_op(input vec_t v);
        rv32i_pkg::decode_info_t op;
        op         = '0;
        op.opcode  = v.opcode;
        op.funct3  = v.funct3;
        op.pc      = v.pc;
        op.i_imm   = v.imm[11:0];
        op.b_imm   = v.imm[12:0];
        op.j_imm   = v.imm[20:0];
        op.bp      = v.bp;
        op.bp_addr = v.bp_addr;
        return op;
    endfunction

    task automatic pick_operands(input vec_t v, output logic [31:0] a, output logic [31:0] b);
        a = v.rs1;
        b = v.rs2;
        if (v.mode != 2'd0) begin
            draw_word(a);
        end
        if (v.mode == 2'd1) begin
            draw_word(b);
        end else if (v.mode == 2'd2) begin
            b = a;
        end
    endtask

    // drives one issue, and queues the result unless it will be squashed
    task automatic send_op(input rv32i_pkg::decode_info_t op, input logic [31:0] a,
                           input logic [31:0] b, input bit keep, output outcome_t o);
        expect_t e;
        op.rd_tag   = next_tag;
        next_tag    = next_tag + 1'b1;
        issue_valid = 1'b1;
        issue_op    = op;
        rs1_value   = a;
        rs2_value   = b;
        o = resolve_ref(op, a, b);
        if (keep) begin
            e.due = cycle + 3;
            e.tag = op.rd_tag;
            e.res = o;
            expected_q.push_back(e);
            resolved_total++;
            if (o.taken) begin
                taken_total++;
                btb_valid[op.pc[bp_pkg::BTB_INDEX_BITS+1:2]]  = 1'b1;
                btb_target[op.pc[bp_pkg::BTB_INDEX_BITS+1:2]] = o.target;
            end
            if (o.mispredict) begin
                mispredict_total++;
            end
        end
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic check_lookup(input logic [31:0] pc);
        logic [bp_pkg::BTB_INDEX_BITS-1:0] idx;
        idx       = pc[bp_pkg::BTB_INDEX_BITS+1:2];
        lookup_pc = pc;
        @(negedge clk);
        check_value("lookup.hit", 32'(lookup.hit), 32'(btb_valid[idx]));
        if (btb_valid[idx]) begin
            check_value("lookup.target", lookup.target, btb_target[idx]);
        end
    endtask

    task automatic run_entry(input vec_t v);
        rv32i_pkg::decode_info_t op;
        rv32i_pkg::decode_info_t sh;
        logic [31:0]             a;
        logic [31:0]             b;
        outcome_t                main_o;
        outcome_t                sh_o;
        int                      main_due;
        op = make_op(v);
        pick_operands(v, a, b);
        // never-taken follower at the next pc
        sh        = '0;
        sh.opcode = rv32i_pkg::op_b_br;
        sh.funct3 = f_bne;
        sh.pc     = v.pc + 32'd4;
        while (!issue_ready) begin
            @(negedge clk);
        end
        main_due = cycle + 3;
        send_op(op, a, b, 1'b1, main_o);
        @(negedge clk);
        if (v.shadow) begin
            check_value("issue_ready", 32'(issue_ready), 32'h1);
            send_op(sh, 32'h0, 32'h0, !main_o.mispredict, sh_o);
            @(negedge clk);
        end
        issue_valid = 1'b0;
        while (cycle < main_due + 1) begin
            @(negedge clk);
        end
        check_value("redirect_valid", 32'(redirect_valid), 32'(main_o.mispredict));
        if (main_o.mispredict) begin
            check_value("redirect_out.pc", redirect_out.pc, main_o.fix_pc);
            check_value("issue_ready", 32'(issue_ready), 32'h0);
            // offered work must not enter while the redirect waits
            repeat (v.hold) begin
                issue_valid = 1'b1;
                issue_op    = op;
                @(negedge clk);
                check_value("redirect_valid", 32'(redirect_valid), 32'h1);
                check_value("redirect_out.pc", redirect_out.pc, main_o.fix_pc);
                check_value("issue_ready", 32'(issue_ready), 32'h0);
            end
            issue_valid    = 1'b0;
            redirect_ready = 1'b1;
            @(negedge clk);
            redirect_ready = 1'b0;
            check_value("redirect_valid", 32'(redirect_valid), 32'h0);
            check_value("issue_ready", 32'(issue_ready), 32'h1);
            if (v.shadow) begin
                // squashed follower goes round again
                send_op(sh, 32'h0, 32'h0, 1'b1, sh_o);
                @(negedge clk);
                issue_valid = 1'b0;
            end
        end else begin
            check_value("issue_ready", 32'(issue_ready), 32'h1);
        end
        wait_drained();
        check_lookup(v.pc);
    endtask

    // ******************************
    // result monitor
    // ******************************

    always @(negedge clk) begin
        if (!rst) begin
            if (expected_q.size() != 0 && expected_q[0].due == cycle) begin
                head = expected_q.pop_front();
                check_value("result.valid", 32'(result.valid), 32'h1);
                check_value("result.rd_tag", 32'(result.rd_tag), 32'(head.tag));
                check_value("result.rd_value", result.rd_value, head.res.link);
                check_value("result.taken", 32'(result.taken), 32'(head.res.taken));
                check_value("result.mispredict", 32'(result.mispredict),
                            32'(head.res.mispredict));
            end else begin
                check_value("result.valid", 32'(result.valid), 32'h0);
            end
        end
    end

    // ******************************
    // main sequence
    // ******************************

    initial begin
        rst            = 1'b1;
        issue_valid    = 1'b0;
        issue_op       = '0;
        rs1_value      = 32'h0;
        rs2_value      = 32'h0;
        redirect_ready = 1'b0;
        lookup_pc      = 32'h0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_value("issue_ready", 32'(issue_ready), 32'h0);
        @(negedge clk);
        check_value("issue_ready", 32'(issue_ready), 32'h1);
        check_value("redirect_valid", 32'(redirect_valid), 32'h0);
        check_value("resolved_count", 32'(resolved_count), 32'h0);
        check_value("taken_count", 32'(taken_count), 32'h0);
        check_value("mispredict_count", 32'(mispredict_count), 32'h0);
        check_lookup(32'h0000_2000);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_entry(vectors[i]);
        end
        check_value("resolved_count", 32'(resolved_count), 32'(resolved_total));
        check_value("taken_count", 32'(taken_count), 32'(taken_total));
        check_value("mispredict_count", 32'(mispredict_count), 32'(mispredict_total));
        $display("TEST OK");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the run timed out before all table entries finished");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* design/branch_resolve_top.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_top (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        issue_valid,
    input  wire rv32i_pkg::decode_info_t     issue_op,
    input  wire logic [31:0]                 rs1_value,
    input  wire logic [31:0]                 rs2_value,
    output logic                             issue_ready,
    output bp_pkg::br_result_t               result,
    output logic                             redirect_valid,
    output bp_pkg::redirect_t                redirect_out,
    input  wire logic                        redirect_ready,
    input  wire logic [31:0]                 lookup_pc,
    output bp_pkg::btb_rd_t                  lookup,
    output logic [bp_pkg::PERF_CNT_BITS-1:0] resolved_count,
    output logic [bp_pkg::PERF_CNT_BITS-1:0] taken_count,
    output logic [bp_pkg::PERF_CNT_BITS-1:0] mispredict_count
);

    logic              start;
    logic              flush;
    logic              redirect_req;
    bp_pkg::redirect_t redirect;
    bp_pkg::btb_wr_t   btb_wr;

    // issue handshake
    assign start = issue_valid && issue_ready;

    branch_unit branch_unit_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .op           (issue_op),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .flush        (flush),
        .result       (result),
        .btb_wr       (btb_wr),
        .redirect_req (redirect_req),
        .redirect     (redirect)
    );

    btb btb_i (
        .clk       (clk),
        .rst       (rst),
        .lookup_pc (lookup_pc),
        .lookup    (lookup),
        .wr        (btb_wr)
    );

    redirect_ctrl redirect_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_req   (redirect_req),
        .redirect_in    (redirect),
        .redirect_ready (redirect_ready),
        .redirect_valid (redirect_valid),
        .redirect_out   (redirect_out),
        .flush          (flush),
        .issue_ready    (issue_ready)
    );

    branch_perf_counters branch_perf_counters_i (
        .clk              (clk),
        .rst              (rst),
        .result           (result),
        .resolved_count   (resolved_count),
        .taken_count      (taken_count),
        .mispredict_count (mispredict_count)
    );

endmodule

`default_nettype wire

/* design/branch_perf_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_perf_counters (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire bp_pkg::br_result_t             result,
    output logic [bp_pkg::PERF_CNT_BITS-1:0]    resolved_count,
    output logic [bp_pkg::PERF_CNT_BITS-1:0]    taken_count,
    output logic [bp_pkg::PERF_CNT_BITS-1:0]    mispredict_count
);

    logic [bp_pkg::PERF_EVENTS-1:0]   events;
    logic [bp_pkg::PERF_CNT_BITS-1:0] counts [bp_pkg::PERF_EVENTS];

    // 0 resolved, 1 taken, 2 mispredicted
    assign events[0] = result.valid;
    assign events[1] = result.valid && result.taken;
    assign events[2] = result.valid && result.mispredict;

    // ******************************
    // saturating counters
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::PERF_EVENTS; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < bp_pkg::PERF_EVENTS; i++) begin
                // stick at all ones
                if (events[i] && (counts[i] != '1)) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

    assign resolved_count   = counts[0];
    assign taken_count      = counts[1];
    assign mispredict_count = counts[2];

endmodule

`default_nettype wire

/* design/redirect_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module redirect_ctrl (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              redirect_req,
    input  wire bp_pkg::redirect_t redirect_in,
    input  wire logic              redirect_ready,
    output logic                   redirect_valid,
    output bp_pkg::redirect_t      redirect_out,
    output logic                   flush,
    output logic                   issue_ready
);

    typedef enum logic [1:0] {
        st_reset,
        st_idle,
        st_pending
    } state_t;

    state_t state;
    state_t state_next;
    logic   capture;

    // ******************************
    // state register
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_reset;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_reset: begin
                state_next = st_idle;
            end
            st_idle: begin
                if (redirect_req) begin
                    state_next = st_pending;
                end
            end
            st_pending: begin
                // hold until the front end takes it
                if (redirect_ready) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_reset;
            end
        endcase
    end

    // ******************************
    // redirect target
    // ******************************

    assign capture = (state == st_idle) && redirect_req;

    always_ff @(posedge clk) begin
        if (capture) begin
            redirect_out <= redirect_in;
        end
    end

    assign redirect_valid = (state == st_pending);
    assign issue_ready    = (state == st_idle);

    // squash younger work on the request cycle and while waiting
    assign flush = capture || (state == st_pending);

endmodule

`default_nettype wire

/* design/btb.sv */
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic [31:0]     lookup_pc,
    output bp_pkg::btb_rd_t      lookup,
    input  wire bp_pkg::btb_wr_t wr
);

    logic [bp_pkg::BTB_ENTRIES-1:0]    valid_bits;
    logic [31:0]                       targets [bp_pkg::BTB_ENTRIES];
    logic [bp_pkg::BTB_INDEX_BITS-1:0] rd_index;
    logic                              hit_q;
    logic [31:0]                       target_q;

    // word-aligned pc, so bit 2 upwards
    assign rd_index = lookup_pc[bp_pkg::BTB_INDEX_BITS+1:2];

    // ******************************
    // storage
    // ******************************

    // whole valid vector clears in one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (wr.valid) begin
            valid_bits[wr.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            targets[wr.index] <= wr.target;
        end
    end

    // ******************************
    // registered lookup
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= valid_bits[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        target_q <= targets[rd_index];
    end

    always_comb begin
        lookup.hit    = hit_q;
        lookup.target = target_q;
    end

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    start,
    input  wire rv32i_pkg::decode_info_t op,
    input  wire logic [31:0]             rs1_value,
    input  wire logic [31:0]             rs2_value,
    input  wire logic                    flush,
    output bp_pkg::br_result_t           result,
    output bp_pkg::btb_wr_t              btb_wr,
    output logic                         redirect_req,
    output bp_pkg::redirect_t            redirect
);

    // stage one
    logic                    s1_valid;
    rv32i_pkg::decode_info_t s1_op;
    logic [31:0]             s1_rs1;
    logic [31:0]             s1_rs2;

    // stage two evaluation
    logic [31:0] i_off;
    logic [31:0] b_off;
    logic [31:0] j_off;
    logic        cmp_taken;
    logic        eval_taken;
    logic [31:0] eval_target;
    logic [31:0] eval_link;

    logic                    s2_valid;
    rv32i_pkg::decode_info_t s2_op;
    logic                    s2_taken;
    logic [31:0]             s2_target;
    logic [31:0]             s2_link;

    // redirect rule
    logic        mispredict;
    logic [31:0] seq_pc;
    logic [31:0] fix_pc;

    // output stage
    logic                                out_valid;
    logic                                out_wr_valid;
    logic                                out_redirect;
    logic [rv32i_pkg::PHYS_TAG_BITS-1:0] out_tag;
    logic [31:0]                         out_link;
    logic                                out_taken;
    logic [bp_pkg::BTB_INDEX_BITS-1:0]   out_index;
    logic [31:0]                         out_target;
    logic [31:0]                         out_fix_pc;

    // ******************************
    // valid pipeline
    // ******************************

    // flush squashes everything younger than the output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            out_valid    <= 1'b0;
            out_wr_valid <= 1'b0;
            out_redirect <= 1'b0;
        end else begin
            s1_valid     <= start && !flush;
            s2_valid     <= s1_valid && !flush;
            out_valid    <= s2_valid && !flush;
            out_wr_valid <= s2_valid && !flush && s2_taken;
            out_redirect <= s2_valid && !flush && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        s1_op      <= op;
        s1_rs1     <= rs1_value;
        s1_rs2     <= rs2_value;
        s2_op      <= s1_op;
        s2_taken   <= eval_taken;
        s2_target  <= eval_target;
        s2_link    <= eval_link;
        out_tag    <= s2_op.rd_tag;
        out_link   <= s2_link;
        out_taken  <= s2_taken;
        out_index  <= s2_op.pc[bp_pkg::BTB_INDEX_BITS+1:2];
        out_target <= s2_target;
        out_fix_pc <= fix_pc;
    end

    // ******************************
    // stage two
    // ******************************

    assign i_off = {{20{s1_op.i_imm[11]}}, s1_op.i_imm};
    assign b_off = {{19{s1_op.b_imm[12]}}, s1_op.b_imm};
    assign j_off = {{11{s1_op.j_imm[20]}}, s1_op.j_imm};

    always_comb begin
        case (rv32i_pkg::branch_f3_t'(s1_op.funct3))
            rv32i_pkg::branch_f3_beq:  cmp_taken = (s1_rs1 == s1_rs2);
            rv32i_pkg::branch_f3_bne:  cmp_taken = (s1_rs1 != s1_rs2);
            rv32i_pkg::branch_f3_blt:  cmp_taken = ($signed(s1_rs1) < $signed(s1_rs2));
            rv32i_pkg::branch_f3_bge:  cmp_taken = ($signed(s1_rs1) >= $signed(s1_rs2));
            rv32i_pkg::branch_f3_bltu: cmp_taken = (s1_rs1 < s1_rs2);
            rv32i_pkg::branch_f3_bgeu: cmp_taken = (s1_rs1 >= s1_rs2);
            default:                   cmp_taken = 1'b0;
        endcase
    end

    always_comb begin
        eval_taken  = 1'b0;
        eval_target = s1_op.pc + b_off;
        eval_link   = 32'h0;
        case (s1_op.opcode)
            rv32i_pkg::op_b_jal: begin
                eval_taken  = 1'b1;
                eval_target = s1_op.pc + j_off;
                eval_link   = s1_op.pc + 32'd4;
            end
            rv32i_pkg::op_b_jalr: begin
                eval_taken  = 1'b1;
                eval_target = (s1_rs1 + i_off) & ~32'h1;
                eval_link   = s1_op.pc + 32'd4;
            end
            rv32i_pkg::op_b_br: begin
                eval_taken = cmp_taken;
            end
            default: begin
                eval_taken = 1'b0;
            end
        endcase
    end

    // ******************************
    // redirect rule
    // ******************************

    assign seq_pc = s2_op.pc + 32'd4;

    always_comb begin
        mispredict = 1'b0;
        fix_pc     = s2_target;
        if (s2_op.bp && !s2_taken) begin
            mispredict = 1'b1;
            fix_pc     = seq_pc;
        end else if (!s2_op.bp && s2_taken) begin
            mispredict = 1'b1;
        end else if (s2_op.bp && s2_taken && (s2_op.bp_addr != s2_target)) begin
            // right direction, wrong target
            mispredict = 1'b1;
        end
    end

    always_comb begin
        result.valid      = out_valid;
        result.rd_tag     = out_tag;
        result.rd_value   = out_link;
        result.taken      = out_taken;
        result.mispredict = out_redirect;
        btb_wr.valid      = out_wr_valid;
        btb_wr.index      = out_index;
        btb_wr.target     = out_target;
        redirect_req      = out_redirect;
        redirect.pc       = out_fix_pc;
    end

endmodule

`default_nettype wire

/* design/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // ******************************
    // sizing
    // ******************************

    localparam int unsigned BTB_INDEX_BITS = 8;
    localparam int unsigned BTB_ENTRIES    = 1 << BTB_INDEX_BITS;
    localparam int unsigned PERF_CNT_BITS  = 16;
    localparam int unsigned PERF_EVENTS    = 3;

    // ******************************
    // branch target buffer
    // ******************************

    typedef struct packed {
        logic                      valid;
        logic [BTB_INDEX_BITS-1:0] index;
        logic [31:0]               target;
    } btb_wr_t;

    typedef struct packed {
        logic        hit;
        logic [31:0] target;
    } btb_rd_t;

    // ******************************
    // resolution
    // ******************************

    typedef struct packed {
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic                                valid;
        logic [rv32i_pkg::PHYS_TAG_BITS-1:0] rd_tag;
        logic [31:0]                         rd_value;
        logic                                taken;
        logic                                mispredict;
    } br_result_t;

endpackage

`default_nettype wire

/* design/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    // ******************************
    // sizing
    // ******************************

    localparam int unsigned XLEN          = 32;
    localparam int unsigned PHYS_TAG_BITS = 6;

    // ******************************
    // major opcodes
    // ******************************

    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } op_b_t;

    // funct3 of conditional branches
    typedef enum logic [2:0] {
        branch_f3_beq  = 3'b000,
        branch_f3_bne  = 3'b001,
        branch_f3_blt  = 3'b100,
        branch_f3_bge  = 3'b101,
        branch_f3_bltu = 3'b110,
        branch_f3_bgeu = 3'b111
    } branch_f3_t;

    // immediates are kept raw, the branch unit sign-extends them
    typedef struct packed {
        op_b_t                    opcode;
        logic [2:0]               funct3;
        logic [XLEN-1:0]          pc;
        logic [11:0]              i_imm;
        logic [12:0]              b_imm;
        logic [20:0]              j_imm;
        logic                     bp;
        logic [XLEN-1:0]          bp_addr;
        logic [PHYS_TAG_BITS-1:0] rd_tag;
    } decode_info_t;

endpackage

`default_nettype wire
